// File: sim.f
lsu_pkg.sv
lsu_byte_align.sv
lsu_store_pipe.sv
lsu_fwd_match.sv
lsu_wr_buffer.sv
lsu_store_count.sv
lsu_bus_fsm.sv
lsu_bus_intf.sv
lsu_bus_assertions.sv
tb_lsu_bus_intf.sv

// File: tb_lsu_bus_intf.sv
`timescale 1ns/10ps

module tb_lsu_bus_intf;
  import lsu_pkg::*;

  localparam int          NUM_REQ = 400;
  localparam int          RST_CYC = 16;
  localparam logic [31:0] BASE    = 32'h0000_0100;  // four words from here

  logic            clk;
  logic            rst_n;
  lsu_req_t        lsu_req;
  logic            lsu_ready;
  logic            lsu_freeze_dc3;
  ld_result_t      ld_result;
  logic            bus_req;
  logic            bus_ack;
  bus_req_t        bus_pkt;
  logic [XLEN-1:0] bus_rdata;

  integer          seed = 32'h7fbe_f320;
  logic [7:0]      ref_mem [16];  // program order view
  logic [7:0]      bus_mem [16];  // what the bus has written
  bus_req_t        exp_wr [$];
  logic [XLEN-1:0] exp_ld [$];

  lsu_bus_intf dut0 (
    .clk, .rst_n, .lsu_req, .bus_ack, .bus_rdata,
    .lsu_ready, .lsu_freeze_dc3, .ld_result, .bus_req, .bus_pkt
  );

  bind lsu_bus_intf lsu_bus_assertions chk0 (
    .clk(clk), .rst_n(rst_n), .lsu_req(lsu_req), .lsu_ready(lsu_ready),
    .lsu_freeze_dc3(lsu_freeze_dc3), .ld_result(ld_result), .bus_req(bus_req),
    .bus_ack(bus_ack), .bus_pkt(bus_pkt)
  );

  function automatic logic [7:0] fill_byte(logic [31:0] a);
    return a[31:24] ^ a[23:16] ^ a[15:8] ^ a[7:0] ^ 8'h3c;
  endfunction

  task automatic stop_on_error(input string msg);
    $display("Fail at %0t: %s", $time, msg);
    $display("Something failed");
    $fatal(1, "stopped at first error");
  endtask

  function automatic lsu_req_t random_request();
    lsu_req_t    r;
    logic [31:0] rnd;
    logic [1:0]  off;
    r       = '0;
    r.valid = 1'b1;
    rnd     = $random(seed);
    r.load  = rnd[0];
    r.store = ~rnd[0];
    case (rnd[15:8] % 3)
      0:       r.size = SZ_BYTE;
      1:       r.size = SZ_HALF;
      default: r.size = SZ_WORD;
    endcase
    off = rnd[17:16];
    if (r.size == SZ_HALF) off[0] = 1'b0;  // keep it aligned
    if (r.size == SZ_WORD) off = 2'b00;
    r.addr = BASE | {28'd0, rnd[21:20], off};
    r.data = $random(seed);
    return r;
  endfunction

  // expected effect of an accepted request, built from the size/offset rule
  task automatic record_request(input lsu_req_t r);
    bus_req_t        w;
    logic [XLEN-1:0] d;
    int              nb;
    int              lane;
    nb = 1 << r.size;
    d  = '0;
    w  = '{write: 1'b1, waddr: r.addr[31:2], byteen: '0, wdata: '0};
    for (int i = 0; i < nb; i++) begin
      lane = r.addr[1:0] + i;
      if (r.store) begin
        w.byteen[lane]          = 1'b1;
        w.wdata[8*lane +: 8]    = r.data[8*i +: 8];
        ref_mem[r.addr[3:0] + i] = r.data[8*i +: 8];
      end else begin
        d[8*i +: 8] = ref_mem[r.addr[3:0] + i];  // zero-extended above
      end
    end
    if (r.store) exp_wr.push_back(w);
    else exp_ld.push_back(d);
  endtask

  task automatic check_load();
    logic [XLEN-1:0] exp;
    assert (exp_ld.size() > 0) else stop_on_error("load result with no load outstanding");
    exp = exp_ld.pop_front();
    assert (ld_result.data == exp)
      else stop_on_error($sformatf("load data %h, expected %h", ld_result.data, exp));
  endtask

  task automatic serve_bus();
    bus_req_t exp;
    int       wbase;
    wbase = {bus_pkt.waddr[1:0], 2'b00};
    if (bus_pkt.write) begin
      assert (exp_wr.size() > 0) else stop_on_error("bus write with no store outstanding");
      exp = exp_wr.pop_front();
      assert (bus_pkt == exp)
        else stop_on_error($sformatf("bus write %h, expected %h", bus_pkt, exp));
      for (int b = 0; b < NBYTES; b++) begin
        if (bus_pkt.byteen[b]) bus_mem[wbase + b] = bus_pkt.wdata[8*b +: 8];
      end
    end else begin
      for (int b = 0; b < NBYTES; b++) bus_rdata[8*b +: 8] = bus_mem[wbase + b];
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ********************
  // stimulus
  // ********************
  initial begin : main
    logic [31:0] rnd;
    rst_n     = 1'b0;
    lsu_req   = '0;
    bus_ack   = 1'b0;
    bus_rdata = '0;
    for (int i = 0; i < 16; i++) begin
      ref_mem[i] = fill_byte(BASE + i);
      bus_mem[i] = ref_mem[i];
    end
    repeat (RST_CYC) @(posedge clk);
    #1 rst_n = 1'b1;
    for (int n = 0; n < NUM_REQ; n++) begin
      lsu_req = random_request();
      do @(negedge clk); while (!lsu_ready);  // taken on the next edge
      @(posedge clk);
      #1 lsu_req.valid = 1'b0;
      rnd = $random(seed);
      if (rnd[2:0] == 3'd0) begin
        @(posedge clk);
        #1;
      end
    end
    while (exp_ld.size() != 0 || exp_wr.size() != 0) @(negedge clk);
    repeat (8) @(posedge clk);
    if (dut0.chk0.errors == 0) begin
      $display("Everything OK");
      $finish;
    end else begin
      $display("Something failed");
      $fatal(1, "the bound checker reported an error");
    end
  end

  // outputs are stable at the falling edge
  always @(negedge clk) begin
    if (rst_n) begin
      if (ld_result.valid) check_load();  // older load first
      if (lsu_req.valid && lsu_ready) record_request(lsu_req);
    end
  end

  // memory side of the four-phase handshake
  initial begin : responder
    logic [31:0] rnd;
    forever begin
      @(negedge clk);
      if (bus_req) begin
        rnd = $random(seed);
        repeat (rnd[1:0]) @(posedge clk);  // 0 to 3 cycles
        @(posedge clk);
        #1;
        serve_bus();
        bus_ack = 1'b1;
        do @(negedge clk); while (bus_req);
        @(posedge clk);
        #1 bus_ack = 1'b0;
      end
    end
  end

  initial begin : checker_watch
    wait (dut0.chk0.errors != 0);
    $display("Something failed");
    $fatal(1, "an assertion in the bound checker failed");
  end

  initial begin : watchdog
    #((RST_CYC + NUM_REQ * 40) * 10);
    $display("Timeout: the requests did not complete in time");
    $display("Something failed");
    $fatal(1, "watchdog expired");
  end

endmodule

// File: lsu_bus_assertions.sv
`timescale 1ns/10ps

module lsu_bus_assertions (
  input logic                clk,
  input logic                rst_n,
  input lsu_pkg::lsu_req_t   lsu_req,
  input logic                lsu_ready,
  input logic                lsu_freeze_dc3,
  input lsu_pkg::ld_result_t ld_result,
  input logic                bus_req,
  input logic                bus_ack,
  input lsu_pkg::bus_req_t   bus_pkt
);
  import lsu_pkg::*;

  int unsigned           errors = 0;  // watched by the testbench top
  logic                  ld_accept;
  logic                  st_accept;
  logic                  wr_end;
  logic                  ack_q;
  logic [WBUF_CNT_W-1:0] pend;        // stores accepted, not yet written

  assign ld_accept = lsu_req.valid & lsu_req.load & lsu_ready;
  assign st_accept = lsu_req.valid & lsu_req.store & lsu_ready;
  assign wr_end    = ack_q & ~bus_ack & bus_pkt.write;  // write ack fell

  // stores in flight as seen from the pins
  always_ff @(posedge clk) begin
    ack_q <= bus_ack;
    if (!rst_n) begin
      pend <= '0;
    end else begin
      pend <= pend + WBUF_CNT_W'(st_accept) - WBUF_CNT_W'(wr_end);
    end
  end

  // ********************
  // reset and handshake
  // ********************
  a_reset: assert property (@(posedge clk) $rose(rst_n) |->
      !bus_req && !lsu_freeze_dc3 && !ld_result.valid && lsu_ready)
    else begin errors++; $error("Fail at %0t: outputs not idle after reset", $time); end

  a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
      bus_req && !bus_ack |=> bus_req)
    else begin errors++; $error("Fail at %0t: bus_req dropped before ack", $time); end

  a_pkt_stable: assert property (@(posedge clk) disable iff (!rst_n)
      bus_req |=> !bus_req || $stable(bus_pkt))
    else begin errors++; $error("Fail at %0t: bus_pkt changed during request", $time); end

  a_req_rise: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(bus_req) |-> !bus_ack)
    else begin errors++; $error("Fail at %0t: bus_req rose with ack high", $time); end

  a_req_fall: assert property (@(posedge clk) disable iff (!rst_n)
      $fell(bus_req) |-> $past(bus_ack))
    else begin errors++; $error("Fail at %0t: bus_req fell without ack", $time); end

  // ********************
  // ordering and flow
  // ********************
  a_rd_order: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(bus_req) && !bus_pkt.write |-> pend == '0)
    else begin errors++; $error("Fail at %0t: read started with stores pending", $time); end

  a_backpressure: assert property (@(posedge clk) disable iff (!rst_n)
      (lsu_freeze_dc3 || pend >= WBUF_CNT_W'(WBUF_DEPTH)) |-> !lsu_ready)
    else begin errors++; $error("Fail at %0t: ready high under back-pressure", $time); end

  // a load either returns next cycle or freezes, never both
  a_ld_timing: assert property (@(posedge clk) disable iff (!rst_n)
      ld_accept |=> (ld_result.valid != lsu_freeze_dc3))
    else begin errors++; $error("Fail at %0t: load neither returned nor froze", $time); end

  a_unfreeze: assert property (@(posedge clk) disable iff (!rst_n)
      $fell(lsu_freeze_dc3) |-> ld_result.valid)
    else begin errors++; $error("Fail at %0t: freeze fell without load result", $time); end

endmodule

// File: lsu_bus_intf.sv
`timescale 1ns/10ps

module lsu_bus_intf (
  input  logic                     clk,
  input  logic                     rst_n,
  input  lsu_pkg::lsu_req_t        lsu_req,
  input  logic                     bus_ack,
  input  logic [lsu_pkg::XLEN-1:0] bus_rdata,
  output logic                     lsu_ready,
  output logic                     lsu_freeze_dc3,
  output lsu_pkg::ld_result_t      ld_result,
  output logic                     bus_req,
  output lsu_pkg::bus_req_t        bus_pkt
);
  import lsu_pkg::*;

  lsu_req_t                    st_req, ld_req;
  store_ent_t                  st_ent, ld_ent;
  store_ent_t                  dc3_ent, dc4_ent, dc5_ent;
  store_ent_t                  head_ent, miss_req_dc3;
  store_ent_t [WBUF_DEPTH-1:0] buf_ents;
  logic                        room, none_pending, buf_empty;
  logic                        pop, write_done;
  logic                        full_hit_dc3, miss_dc3;
  logic [XLEN-1:0]             fwd_data_dc3;

  assign lsu_ready = ~lsu_freeze_dc3 & room;

  // accepted request split into its store and load view
  always_comb begin
    st_req       = lsu_req;
    st_req.valid = lsu_req.valid & lsu_ready & lsu_req.store;
    ld_req       = lsu_req;
    ld_req.valid = lsu_req.valid & lsu_ready & lsu_req.load;
  end

  lsu_byte_align st_align (.req(st_req), .ent(st_ent));
  lsu_byte_align ld_align (.req(ld_req), .ent(ld_ent));

  lsu_store_pipe store_pipe (
    .clk, .rst_n,
    .in_ent(st_ent), .in_store(st_req.valid), .freeze(lsu_freeze_dc3),
    .dc3_ent, .dc4_ent, .dc5_ent
  );

  lsu_wr_buffer wr_buffer (
    .clk, .rst_n,
    .push_ent(dc5_ent), .pop,
    .head_ent, .ents(buf_ents), .empty(buf_empty)
  );

  lsu_fwd_match fwd_match (
    .clk, .rst_n,
    .ld_req, .ld_ent, .dc3_ent, .dc4_ent, .dc5_ent, .buf_ents,
    .full_hit_dc3, .fwd_data_dc3, .miss_dc3, .miss_req_dc3
  );

  lsu_store_count store_count (
    .clk, .rst_n,
    .inc(st_req.valid), .dec(write_done),
    .room, .none_pending
  );

  lsu_bus_fsm bus_fsm (
    .clk, .rst_n,
    .head_ent, .buf_empty, .miss_dc3, .miss_req_dc3,
    .full_hit_dc3, .fwd_data_dc3, .none_pending, .bus_ack, .bus_rdata,
    .pop, .write_done, .freeze(lsu_freeze_dc3), .bus_req, .bus_pkt, .ld_result
  );

endmodule

// File: lsu_bus_fsm.sv
`timescale 1ns/10ps

module lsu_bus_fsm (
  input  logic                     clk,
  input  logic                     rst_n,
  input  lsu_pkg::store_ent_t      head_ent,
  input  logic                     buf_empty,
  input  logic                     miss_dc3,
  input  lsu_pkg::store_ent_t      miss_req_dc3,
  input  logic                     full_hit_dc3,
  input  logic [lsu_pkg::XLEN-1:0] fwd_data_dc3,
  input  logic                     none_pending,
  input  logic                     bus_ack,
  input  logic [lsu_pkg::XLEN-1:0] bus_rdata,
  output logic                     pop,
  output logic                     write_done,
  output logic                     freeze,
  output logic                     bus_req,
  output lsu_pkg::bus_req_t        bus_pkt,
  output lsu_pkg::ld_result_t      ld_result
);
  import lsu_pkg::*;

  typedef enum logic [2:0] {
    S_IDLE,
    S_WR_REQ,
    S_WR_ACK_LO,
    S_RD_REQ,
    S_RD_ACK_LO
  } state_e;

  state_e          state, state_nxt;
  logic            miss_pend;   // load waiting for its bus read
  store_ent_t      miss_ent;
  logic            start_rd, start_wr, rd_ack;
  logic            rd_valid_q;
  logic [XLEN-1:0] rd_data_q;
  logic [XLEN-1:0] rd_masked, rd_aligned;
  logic [1:0]      rd_off;

  // a read goes only once every older store is on the bus
  assign start_rd = (state == S_IDLE) & ~bus_ack & miss_pend & none_pending;
  assign start_wr = (state == S_IDLE) & ~bus_ack & ~start_rd & ~buf_empty;
  assign rd_ack   = (state == S_RD_REQ) & bus_ack;

  // ********************
  // next state
  // ********************
  always_comb begin
    state_nxt = state;
    case (state)
      S_IDLE:      if (start_rd) state_nxt = S_RD_REQ;
                   else if (start_wr) state_nxt = S_WR_REQ;
      S_WR_REQ:    if (bus_ack) state_nxt = S_WR_ACK_LO;
      S_WR_ACK_LO: if (!bus_ack) state_nxt = S_IDLE;
      S_RD_REQ:    if (bus_ack) state_nxt = S_RD_ACK_LO;
      S_RD_ACK_LO: if (!bus_ack) state_nxt = S_IDLE;
      default:     state_nxt = S_IDLE;
    endcase
  end

  // lowest enabled lane gives the offset of the load
  always_comb begin
    rd_off = 2'd0;
    for (int b = NBYTES - 1; b >= 0; b--) begin
      if (miss_ent.byteen[b]) rd_off = 2'(b);
    end
    for (int b = 0; b < NBYTES; b++) begin
      rd_masked[8*b +: 8] = bus_rdata[8*b +: 8] & {8{miss_ent.byteen[b]}};
    end
    rd_aligned = rd_masked >> {rd_off, 3'b000};
  end

  always_ff @(posedge clk) begin
    state      <= state_nxt;
    rd_valid_q <= rd_ack;
    if (rd_ack)   miss_pend <= 1'b0;
    if (miss_dc3) miss_pend <= 1'b1;
    if (!rst_n) begin
      state      <= S_IDLE;
      rd_valid_q <= 1'b0;
      miss_pend  <= 1'b0;
    end
  end

  // payload, held steady while bus_req is up
  always_ff @(posedge clk) begin
    if (miss_dc3) miss_ent <= miss_req_dc3;
    if (rd_ack)   rd_data_q <= rd_aligned;  // sampled on the first ack edge
    if (start_wr) begin
      bus_pkt <= '{write: 1'b1, waddr: head_ent.waddr, byteen: head_ent.byteen,
                   wdata: head_ent.data};
    end else if (start_rd) begin
      bus_pkt <= '{write: 1'b0, waddr: miss_ent.waddr, byteen: miss_ent.byteen,
                   wdata: '0};
    end
  end

  assign bus_req    = (state == S_WR_REQ) | (state == S_RD_REQ);
  assign pop        = (state == S_WR_ACK_LO) & ~bus_ack;  // ack fell, write done
  assign write_done = pop;
  assign freeze     = miss_dc3 | miss_pend;

  always_comb begin
    ld_result.valid = full_hit_dc3 | rd_valid_q;
    ld_result.data  = full_hit_dc3 ? fwd_data_dc3 : rd_data_q;
  end

endmodule

// File: lsu_store_count.sv
`timescale 1ns/10ps

module lsu_store_count (
  input  logic clk,
  input  logic rst_n,
  input  logic inc,           // store accepted
  input  logic dec,           // store written on the bus
  output logic room,
  output logic none_pending
);
  import lsu_pkg::*;

  logic [WBUF_CNT_W-1:0] cnt;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cnt <= '0;
    end else begin
      case ({inc, dec})
        2'b10:   cnt <= cnt + 1'b1;
        2'b01:   cnt <= cnt - 1'b1;
        default: cnt <= cnt;  // both or neither
      endcase
    end
  end

  assign room         = (cnt < WBUF_CNT_W'(WBUF_DEPTH));
  assign none_pending = (cnt == '0);

endmodule

// File: lsu_wr_buffer.sv
`timescale 1ns/10ps

module lsu_wr_buffer (
  input  logic                                         clk,
  input  logic                                         rst_n,
  input  lsu_pkg::store_ent_t                          push_ent,
  input  logic                                         pop,
  output lsu_pkg::store_ent_t                          head_ent,
  output lsu_pkg::store_ent_t [lsu_pkg::WBUF_DEPTH-1:0] ents,
  output logic                                         empty
);
  import lsu_pkg::*;

  store_ent_t [WBUF_DEPTH-1:0] mem;
  logic [WBUF_CNT_W-1:0]       wr_ptr;  // msb is the wrap bit
  logic [WBUF_CNT_W-1:0]       rd_ptr;
  logic [WBUF_CNT_W-1:0]       used;
  logic [WBUF_CNT_W-1:0]       slot;

  // ********************
  // storage and pointers
  // ********************
  always_ff @(posedge clk) begin
    if (push_ent.valid) begin
      mem[wr_ptr[WBUF_CNT_W-2:0]] <= push_ent;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push_ent.valid) wr_ptr <= wr_ptr + 1'b1;
      if (pop)            rd_ptr <= rd_ptr + 1'b1;
    end
  end

  assign used  = wr_ptr - rd_ptr;
  assign empty = (used == '0);

  // rotated view, entry 0 is the oldest
  always_comb begin
    slot = rd_ptr;
    for (int i = 0; i < WBUF_DEPTH; i++) begin
      slot           = rd_ptr + WBUF_CNT_W'(i);
      ents[i]        = mem[slot[WBUF_CNT_W-2:0]];
      ents[i].valid  = (WBUF_CNT_W'(i) < used);  // stale slots never match
    end
  end

  assign head_ent = ents[0];

endmodule

// File: lsu_fwd_match.sv
`timescale 1ns/10ps

module lsu_fwd_match (
  input  logic                                         clk,
  input  logic                                         rst_n,
  input  lsu_pkg::lsu_req_t                            ld_req,
  input  lsu_pkg::store_ent_t                          ld_ent,
  input  lsu_pkg::store_ent_t                          dc3_ent,
  input  lsu_pkg::store_ent_t                          dc4_ent,
  input  lsu_pkg::store_ent_t                          dc5_ent,
  input  lsu_pkg::store_ent_t [lsu_pkg::WBUF_DEPTH-1:0] buf_ents,  // oldest at 0
  output logic                                         full_hit_dc3,
  output logic [lsu_pkg::XLEN-1:0]                     fwd_data_dc3,
  output logic                                         miss_dc3,
  output lsu_pkg::store_ent_t                          miss_req_dc3
);
  import lsu_pkg::*;

  store_ent_t [FWD_SRCS-1:0] srcs;  // index 0 is the youngest store
  logic [NBYTES-1:0]         byte_hit;
  logic [XLEN-1:0]           fwd_lanes;
  logic [XLEN-1:0]           fwd_data_dc2;
  logic                      ld_go_dc2;
  logic                      full_hit_dc2;

  // age order: pipe first, then buffer youngest to oldest
  always_comb begin
    srcs[0] = dc3_ent;
    srcs[1] = dc4_ent;
    srcs[2] = dc5_ent;
    for (int i = 0; i < WBUF_DEPTH; i++) begin
      srcs[3+i] = buf_ents[WBUF_DEPTH-1-i];
    end
  end

  // ********************
  // per-byte hit and select
  // ********************
  always_comb begin
    byte_hit  = '0;
    fwd_lanes = '0;
    // walk oldest to youngest so the youngest hit is written last
    for (int s = FWD_SRCS - 1; s >= 0; s--) begin
      for (int b = 0; b < NBYTES; b++) begin
        if (srcs[s].valid && (srcs[s].waddr == ld_ent.waddr) &&
            srcs[s].byteen[b] && ld_ent.byteen[b]) begin
          byte_hit[b]         = 1'b1;
          fwd_lanes[8*b +: 8] = srcs[s].data[8*b +: 8];
        end
      end
    end
  end

  assign ld_go_dc2    = ld_req.valid & ld_req.load;
  assign full_hit_dc2 = &(byte_hit | ~ld_ent.byteen);
  // only requested lanes can be nonzero, so the shift also zero-extends
  assign fwd_data_dc2 = fwd_lanes >> {ld_req.addr[1:0], 3'b000};

  always_ff @(posedge clk) begin
    full_hit_dc3      <= ld_go_dc2 & full_hit_dc2;
    miss_dc3          <= ld_go_dc2 & ~full_hit_dc2;  // miss or partial hit
    fwd_data_dc3      <= fwd_data_dc2;
    miss_req_dc3      <= ld_ent;
    miss_req_dc3.data <= '0;
    if (!rst_n) begin
      full_hit_dc3 <= 1'b0;
      miss_dc3     <= 1'b0;
    end
  end

endmodule

// File: lsu_store_pipe.sv
`timescale 1ns/10ps

module lsu_store_pipe (
  input  logic                clk,
  input  logic                rst_n,
  input  lsu_pkg::store_ent_t in_ent,
  input  logic                in_store,
  input  logic                freeze,
  output lsu_pkg::store_ent_t dc3_ent,
  output lsu_pkg::store_ent_t dc4_ent,
  output lsu_pkg::store_ent_t dc5_ent
);

  // ********************
  // dc3 -> dc4 -> dc5
  // ********************
  always_ff @(posedge clk) begin
    dc3_ent <= in_ent;
    dc4_ent <= dc3_ent;
    dc5_ent <= dc4_ent;

    // bubble into dc3 while frozen, older stores keep draining
    dc3_ent.valid <= in_store & ~freeze;
    dc4_ent.valid <= dc3_ent.valid;
    dc5_ent.valid <= dc4_ent.valid;

    if (!rst_n) begin
      dc3_ent.valid <= 1'b0;
      dc4_ent.valid <= 1'b0;
      dc5_ent.valid <= 1'b0;
    end
  end

endmodule

// File: lsu_byte_align.sv
`timescale 1ns/10ps

module lsu_byte_align (
  input  lsu_pkg::lsu_req_t   req,
  output lsu_pkg::store_ent_t ent
);
  import lsu_pkg::*;

  logic [NBYTES-1:0] size_mask;
  logic [NBYTES-1:0] byteen;
  logic [XLEN-1:0]   shifted_data;
  logic [XLEN-1:0]   lane_data;

  always_comb begin
    case (req.size)
      SZ_BYTE: size_mask = 4'b0001;
      SZ_HALF: size_mask = 4'b0011;
      default: size_mask = 4'b1111;  // word
    endcase
  end

  // aligned accesses only, so the shift never leaves the word
  assign byteen       = size_mask << req.addr[1:0];
  assign shifted_data = req.data << {req.addr[1:0], 3'b000};

  // lanes outside the enables are cleared
  always_comb begin
    for (int b = 0; b < NBYTES; b++) begin
      lane_data[8*b +: 8] = shifted_data[8*b +: 8] & {8{byteen[b]}};
    end
  end

  always_comb begin
    ent.valid  = req.valid;
    ent.waddr  = req.addr[XLEN-1:2];
    ent.byteen = byteen;
    ent.data   = lane_data;
  end

endmodule

// File: lsu_pkg.sv
package lsu_pkg;

  // ********************
  // widths and sizes
  // ********************
  localparam int XLEN       = 32;
  localparam int NBYTES     = XLEN / 8;        // byte lanes per word
  localparam int WADDR_W    = XLEN - 2;        // word address bits
  localparam int WBUF_DEPTH = 4;               // also the store-in-flight limit
  localparam int WBUF_CNT_W = 3;
  localparam int FWD_SRCS   = 3 + WBUF_DEPTH;  // dc3, dc4, dc5 plus the buffer

  typedef enum logic [1:0] {
    SZ_BYTE = 2'd0,
    SZ_HALF = 2'd1,
    SZ_WORD = 2'd2
  } lsu_size_e;

  // request as it arrives at dc2
  typedef struct packed {
    logic            valid;
    logic            load;
    logic            store;
    lsu_size_e       size;
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] data;
  } lsu_req_t;

  // store (or load lookup) placed on the byte lanes of its word
  typedef struct packed {
    logic               valid;
    logic [WADDR_W-1:0] waddr;
    logic [NBYTES-1:0]  byteen;
    logic [XLEN-1:0]    data;
  } store_ent_t;

  typedef struct packed {
    logic               write;
    logic [WADDR_W-1:0] waddr;
    logic [NBYTES-1:0]  byteen;
    logic [XLEN-1:0]    wdata;
  } bus_req_t;

  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] data;   // right-aligned, zero-extended
  } ld_result_t;

endpackage
